// ==== filelist.f ====
source/riscv_pkg.sv
source/fetch_stage.sv
source/reg_file.sv
source/alu.sv
source/execute_stage.sv
source/mem_writeback_stage.sv
source/riscv_core.sv
test/riscv_checker.sv
test/riscv_core_assertions.sv
test/tb_riscv_core.sv

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu import riscv_pkg::*; (
  input  insn_t insn,
  input  word_t a,
  input  word_t b,
  input  word_t pc,
  output word_t result,
  output logic  reg_we,
  output logic  store_en,
  output logic  branch_taken,
  output word_t branch_target
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       funct7_zero;
  logic       funct7_alt;
  logic       funct7_ok;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      op2;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign funct7_zero = (funct7 == 7'd0);
  assign funct7_alt = (funct7 == 7'b0100000);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  // immediate forms share the register-register datapath
  assign op2 = (opcode == op_reg_reg) ? b : imm_i;

  // immediate ops ignore funct7 except for shifts, sub and sra take the alternate value
  assign funct7_ok = (opcode == op_reg_imm && funct3 != 3'b001 && funct3 != 3'b101)
                  || funct7_zero
                  || (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));

  assign branch_target = pc + imm_b;

  always_comb begin
    result = '0;
    reg_we = 1'b0;
    store_en = 1'b0;
    branch_taken = 1'b0;
    case (opcode)
      op_lui: begin
        result = {insn[31:12], 12'd0};
        reg_we = 1'b1;
      end
      op_reg_imm, op_reg_reg: begin
        reg_we = funct7_ok;
        case (funct3)
          3'b000: result = (opcode == op_reg_reg && funct7_alt) ? a - op2 : a + op2;
          3'b001: result = a << op2[4:0];
          3'b010: result = {31'd0, $signed(a) < $signed(op2)};
          3'b011: result = {31'd0, a < op2};
          3'b100: result = a ^ op2;
          3'b101: result = funct7_alt ? word_t'($signed(a) >>> op2[4:0]) : a >> op2[4:0];
          3'b110: result = a | op2;
          3'b111: result = a & op2;
        endcase
      end
      op_load: begin
        result = a + imm_i;
        reg_we = (funct3 == 3'b010);
      end
      op_store: begin
        result = a + imm_s;
        store_en = (funct3 == 3'b010);
      end
      op_branch: begin
        case (funct3)
          3'b000: branch_taken = (a == b);
          3'b001: branch_taken = (a != b);
          3'b100: branch_taken = ($signed(a) < $signed(b));
          3'b101: branch_taken = ($signed(a) >= $signed(b));
          3'b110: branch_taken = (a < b);
          3'b111: branch_taken = (a >= b);
          default: branch_taken = 1'b0;
        endcase
      end
      // ecall, bubbles and unknown encodings have no side effects here
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage import riscv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  decode_state_t    decode_state,
  input  word_t            rs1_data,
  input  word_t            rs2_data,
  input  writeback_state_t writeback_state,
  input  word_t            wb_value,
  output reg_idx_t         rs1,
  output reg_idx_t         rs2,
  output logic             load_stall,
  output logic             branch_taken,
  output word_t            branch_target,
  output memory_state_t    memory_state
);

  execute_state_t execute_state;
  opcode_e        d_opcode;
  logic           d_uses_rs1;
  logic           d_uses_rs2;
  reg_idx_t       x_rd;
  word_t          op_a;
  word_t          op_b;
  word_t          alu_result;
  logic           alu_reg_we;
  logic           alu_store_en;

  // newest producer wins, then writeback, then the value read in decode
  function automatic word_t pick_operand(
    input reg_idx_t         src,
    input word_t            held,
    input memory_state_t    m,
    input writeback_state_t w,
    input word_t            w_value
  );
    word_t value;
    value = held;
    if (src != 5'd0 && w.reg_we && w.insn[11:7] == src) begin
      value = w_value;
    end
    if (src != 5'd0 && m.reg_we && m.insn[11:7] == src) begin
      value = m.result;
    end
    return value;
  endfunction

  assign rs1 = decode_state.insn[19:15];
  assign rs2 = decode_state.insn[24:20];
  assign d_opcode = opcode_e'(decode_state.insn[6:0]);
  assign x_rd = execute_state.insn[11:7];

  // store data is left out, it gets bypassed in the memory stage
  always_comb begin
    d_uses_rs1 = 1'b0;
    d_uses_rs2 = 1'b0;
    case (d_opcode)
      op_reg_reg, op_branch: begin
        d_uses_rs1 = 1'b1;
        d_uses_rs2 = 1'b1;
      end
      op_reg_imm, op_load, op_store: begin
        d_uses_rs1 = 1'b1;
      end
      default: begin
        d_uses_rs1 = 1'b0;
      end
    endcase
  end

  assign load_stall = (opcode_e'(execute_state.insn[6:0]) == op_load) && alu_reg_we
                   && (x_rd != 5'd0)
                   && ((d_uses_rs1 && rs1 == x_rd) || (d_uses_rs2 && rs2 == x_rd));

  always_comb begin
    op_a = pick_operand(execute_state.insn[19:15], execute_state.a, memory_state,
                        writeback_state, wb_value);
    op_b = pick_operand(execute_state.insn[24:20], execute_state.b, memory_state,
                        writeback_state, wb_value);
  end

  alu i_alu (
    .insn          (execute_state.insn),
    .a             (op_a),
    .b             (op_b),
    .pc            (execute_state.pc),
    .result        (alu_result),
    .reg_we        (alu_reg_we),
    .store_en      (alu_store_en),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{pc: '0, insn: '0, a: '0, b: '0, cycle_status: cycle_reset};
    end else if (branch_taken) begin
      execute_state <= '{pc: '0, insn: '0, a: '0, b: '0, cycle_status: cycle_taken_branch};
    end else if (load_stall) begin
      // bubble while the consumer waits in decode
      execute_state <= '{pc: '0, insn: '0, a: '0, b: '0, cycle_status: cycle_load2use};
    end else begin
      execute_state <= '{
        pc:           decode_state.pc,
        insn:         decode_state.insn,
        a:            rs1_data,
        b:            rs2_data,
        cycle_status: decode_state.cycle_status
      };
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{
        pc: '0, insn: '0, result: '0, store_data: '0,
        reg_we: 1'b0, store_en: 1'b0, cycle_status: cycle_reset
      };
    end else begin
      memory_state <= '{
        pc:           execute_state.pc,
        insn:         execute_state.insn,
        result:       alu_result,
        store_data:   op_b,
        reg_we:       alu_reg_we,
        store_en:     alu_store_en,
        cycle_status: execute_state.cycle_status
      };
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import riscv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  insn_t         insn_data,
  input  logic          load_stall,
  input  logic          branch_taken,
  input  word_t         branch_target,
  output word_t         imem_addr,
  output decode_state_t decode_state
);

  word_t pc;

  // a taken branch wins over a load stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!load_stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_state <= '{pc: '0, insn: '0, cycle_status: cycle_reset};
    end else if (branch_taken) begin
      // squash the wrong-path fetch
      decode_state <= '{pc: '0, insn: '0, cycle_status: cycle_taken_branch};
    end else if (!load_stall) begin
      decode_state <= '{pc: pc, insn: insn_data, cycle_status: cycle_no_stall};
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_writeback_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_writeback_stage import riscv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  memory_state_t    memory_state,
  input  word_t            load_data,
  output word_t            dmem_addr,
  output word_t            store_data,
  output logic             store_en,
  output writeback_state_t writeback_state,
  output word_t            wb_value,
  output reg_idx_t         rd,
  output logic             reg_we,
  output logic             halt,
  output word_t            trace_pc,
  output insn_t            trace_insn,
  output cycle_status_e    trace_status
);

  reg_idx_t m_rs2;
  logic     store_bypass;

  assign m_rs2 = memory_state.insn[24:20];

  // store data produced by the instruction now in writeback, e.g. a load
  assign store_bypass = reg_we && (rd != 5'd0) && (rd == m_rs2);

  assign dmem_addr = memory_state.result;
  assign store_data = store_bypass ? wb_value : memory_state.store_data;
  assign store_en = memory_state.store_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      writeback_state <= '{
        pc: '0, insn: '0, result: '0, load_data: '0,
        reg_we: 1'b0, cycle_status: cycle_reset
      };
    end else begin
      writeback_state <= '{
        pc:           memory_state.pc,
        insn:         memory_state.insn,
        result:       memory_state.result,
        load_data:    load_data,
        reg_we:       memory_state.reg_we,
        cycle_status: memory_state.cycle_status
      };
    end
  end

  assign wb_value = (opcode_e'(writeback_state.insn[6:0]) == op_load) ?
                    writeback_state.load_data : writeback_state.result;
  assign rd = writeback_state.insn[11:7];
  assign reg_we = writeback_state.reg_we;

  // ecall is the all-zero environ encoding
  assign halt = (writeback_state.insn == {25'd0, op_environ});

  assign trace_pc = writeback_state.pc;
  assign trace_insn = writeback_state.insn;
  assign trace_status = writeback_state.cycle_status;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import riscv_pkg::*; #(
  parameter int num_regs = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  logic     we
);

  word_t regs [num_regs];
  logic  write_live;

  // x0 is cleared by reset and never written afterwards
  assign write_live = we && (rd != 5'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[rd] <= rd_data;
    end
  end

  // decode sees the value writeback is committing this cycle
  assign rs1_data = (write_live && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (write_live && rd == rs2) ? rd_data : regs[rs2];

endmodule

`default_nettype wire

// ==== source/riscv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscv_core import riscv_pkg::*; #(
  parameter int num_regs = 32
) (
  input  logic          clk,
  input  logic          rst,
  output word_t         imem_addr,
  input  insn_t         insn_data,
  output word_t         dmem_addr,
  input  word_t         load_data,
  output word_t         store_data,
  output logic          store_en,
  output logic          halt,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output logic          trace_reg_we,
  output reg_idx_t      trace_rd,
  output word_t         trace_rd_data
);

  decode_state_t    decode_state;
  memory_state_t    memory_state;
  writeback_state_t writeback_state;
  logic             load_stall;
  logic             branch_taken;
  word_t            branch_target;
  reg_idx_t         rs1;
  reg_idx_t         rs2;
  word_t            rs1_data;
  word_t            rs2_data;

  fetch_stage i_fetch_stage (
    .clk           (clk),
    .rst           (rst),
    .insn_data     (insn_data),
    .load_stall    (load_stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .imem_addr     (imem_addr),
    .decode_state  (decode_state)
  );

  // the register write is also the trace of the retiring instruction
  reg_file #(
    .num_regs (num_regs)
  ) i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (trace_rd),
    .rd_data  (trace_rd_data),
    .we       (trace_reg_we)
  );

  execute_stage i_execute_stage (
    .clk             (clk),
    .rst             (rst),
    .decode_state    (decode_state),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .writeback_state (writeback_state),
    .wb_value        (trace_rd_data),
    .rs1             (rs1),
    .rs2             (rs2),
    .load_stall      (load_stall),
    .branch_taken    (branch_taken),
    .branch_target   (branch_target),
    .memory_state    (memory_state)
  );

  mem_writeback_stage i_mem_writeback_stage (
    .clk             (clk),
    .rst             (rst),
    .memory_state    (memory_state),
    .load_data       (load_data),
    .dmem_addr       (dmem_addr),
    .store_data      (store_data),
    .store_en        (store_en),
    .writeback_state (writeback_state),
    .wb_value        (trace_rd_data),
    .rd              (trace_rd),
    .reg_we          (trace_reg_we),
    .halt            (halt),
    .trace_pc        (trace_pc),
    .trace_insn      (trace_insn),
    .trace_status    (trace_status)
  );

endmodule

`default_nettype wire

// ==== source/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  // RV32 widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_branch  = 7'b1100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_lui     = 7'b0110111,
    op_environ = 7'b1110011
  } opcode_e;

  // classifies each cycle as it reaches writeback
  typedef enum logic [2:0] {
    cycle_reset        = 3'd1,
    cycle_no_stall     = 3'd2,
    cycle_taken_branch = 3'd3,
    cycle_load2use     = 3'd4
  } cycle_status_e;

  // state at the start of decode
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e cycle_status;
  } decode_state_t;

  // state at the start of execute, a and b are the register operands
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         a;
    word_t         b;
    cycle_status_e cycle_status;
  } execute_state_t;

  // result is the alu value or the data memory address
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         result;
    word_t         store_data;
    logic          reg_we;
    logic          store_en;
    cycle_status_e cycle_status;
  } memory_state_t;

  // state at the start of writeback
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         result;
    word_t         load_data;
    logic          reg_we;
    cycle_status_e cycle_status;
  } writeback_state_t;

endpackage

`default_nettype wire

// ==== test/riscv_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscv_checker import riscv_pkg::*; #(
  parameter int num_insns = 200
) (
  input  logic          clk,
  input  logic          rst,
  input  word_t         trace_pc,
  input  insn_t         trace_insn,
  input  cycle_status_e trace_status,
  input  logic          trace_reg_we,
  input  reg_idx_t      trace_rd,
  input  word_t         trace_rd_data,
  input  logic          halt,
  input  logic          store_en,
  input  word_t         dmem_addr,
  input  word_t         store_data,
  output logic          finished,
  output int            error_count,
  output int            check_count
);

  // loaded by the testbench before reset ends
  insn_t program_copy [256];
  word_t model_dmem [64];

  word_t         model_regs [32];
  word_t         model_pc;
  int            pending;
  cycle_status_e pending_kind;
  logic          started;
  logic [63:0]   store_q [$];
  int            checks [5];
  int            fails [5];

  function automatic string behavior_name(input int b);
    string name;
    case (b)
      0: name = "retirement order";
      1: name = "register results";
      2: name = "stores";
      3: name = "stall status";
      default: name = "halt";
    endcase
    return name;
  endfunction

  task automatic record_check(input int b, input logic ok, input string msg);
    checks[b]++;
    if (!ok) begin
      fails[b]++;
      $display("Fail %0t: %s", $time, msg);
    end
  endtask

  task automatic record_problem(input int b, input string msg);
    checks[b]++;
    fails[b]++;
    $display("%s", msg);
  endtask

  // RV32I arithmetic, bit 5 of the opcode tells register from immediate form
  function automatic word_t model_op(input insn_t insn, input word_t a, input word_t b);
    word_t r;
    case (insn[14:12])
      3'b000: r = (insn[5] && insn[30]) ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: r = insn[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic model_branch(input logic [2:0] f3, input word_t a, input word_t b);
    logic t;
    case (f3)
      3'b000: t = (a == b);
      3'b001: t = (a != b);
      3'b100: t = ($signed(a) < $signed(b));
      3'b101: t = ($signed(a) >= $signed(b));
      3'b110: t = (a < b);
      default: t = (a >= b);
    endcase
    return t;
  endfunction

  // sources that must be ready in execute, sw data is not one of them
  function automatic logic reads_reg(input insn_t insn, input reg_idx_t r);
    logic hit;
    case (opcode_e'(insn[6:0]))
      op_reg_reg, op_branch: hit = (insn[19:15] == r) || (insn[24:20] == r);
      op_reg_imm, op_load, op_store: hit = (insn[19:15] == r);
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  task automatic retire_insn();
    insn_t       insn;
    reg_idx_t    rd;
    word_t       a;
    word_t       b;
    word_t       value;
    word_t       addr;
    word_t       next_pc;
    logic        writes;
    logic        taken;
    logic        is_ecall;
    logic [63:0] store;
    insn = program_copy[model_pc[9:2]];
    rd = insn[11:7];
    a = model_regs[insn[19:15]];
    b = model_regs[insn[24:20]];
    writes = 1'b0;
    taken = 1'b0;
    value = '0;
    next_pc = model_pc + 32'd4;
    is_ecall = (insn[6:0] == op_environ);
    record_check(0, trace_pc == model_pc && trace_insn == insn,
                 $sformatf("retired pc %h insn %h, expected pc %h insn %h",
                           trace_pc, trace_insn, model_pc, insn));
    case (opcode_e'(insn[6:0]))
      op_lui: begin
        writes = 1'b1;
        value = {insn[31:12], 12'd0};
      end
      op_reg_imm: begin
        writes = 1'b1;
        value = model_op(insn, a, {{20{insn[31]}}, insn[31:20]});
      end
      op_reg_reg: begin
        writes = 1'b1;
        value = model_op(insn, a, b);
      end
      op_load: begin
        writes = 1'b1;
        addr = a + {{20{insn[31]}}, insn[31:20]};
        value = model_dmem[addr[7:2]];
      end
      op_store: begin
        addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
        if (store_q.size() == 0) begin
          record_problem(2, $sformatf("sw at pc %h retired without a store on the data port",
                                      model_pc));
        end else begin
          store = store_q.pop_front();
          record_check(2, store == {addr, b},
                       $sformatf("sw at pc %h stored %h to %h, expected %h to %h",
                                 model_pc, store[31:0], store[63:32], b, addr));
        end
        model_dmem[addr[7:2]] = b;
      end
      op_branch: begin
        taken = model_branch(insn[14:12], a, b);
        if (taken) begin
          next_pc = model_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      default: begin
        value = '0;
      end
    endcase
    if (writes && rd != 5'd0) begin
      record_check(1, trace_reg_we && trace_rd == rd && trace_rd_data == value,
                   $sformatf("pc %h wrote x%0d = %h (we %b), expected x%0d = %h",
                             model_pc, trace_rd, trace_rd_data, trace_reg_we, rd, value));
      model_regs[rd] = value;
    end else if (!writes) begin
      record_check(1, !trace_reg_we, $sformatf("pc %h wrote a register", model_pc));
    end
    if (is_ecall || halt) begin
      record_check(4, is_ecall && halt && model_pc == num_insns * 4,
                   $sformatf("halt %b at pc %h, ecall is at %h", halt, model_pc, num_insns * 4));
    end
    pending = 0;
    if (taken) begin
      pending = 2;
      pending_kind = cycle_taken_branch;
    end else if (insn[6:0] == op_load && rd != 5'd0 && reads_reg(program_copy[next_pc[9:2]], rd)) begin
      pending = 1;
      pending_kind = cycle_load2use;
    end
    model_pc = next_pc;
    if (is_ecall) begin
      if (store_q.size() != 0) begin
        record_problem(2, "stores appeared on the data port that no retired sw made");
      end
      for (int i = 0; i < 5; i++) begin
        $display("%s: %0d checks, %0d failed", behavior_name(i), checks[i], fails[i]);
        check_count += checks[i];
        error_count += fails[i];
      end
      finished = 1'b1;
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < 5; i++) begin
        checks[i] = 0;
        fails[i] = 0;
      end
      model_pc = '0;
      pending = 0;
      started = 1'b0;
      finished = 1'b0;
      error_count = 0;
      check_count = 0;
    end else if (!finished) begin
      if (store_en) begin
        store_q.push_back({dmem_addr, store_data});
      end
      case (trace_status)
        cycle_no_stall: begin
          if (pending != 0) begin
            record_problem(3, $sformatf("%0d %s cycle(s) were missing before pc %h",
                                        pending, pending_kind.name(), model_pc));
          end
          started = 1'b1;
          retire_insn();
        end
        cycle_reset: begin
          if (started) begin
            record_problem(3, "a reset status reached writeback after the first retirement");
          end
        end
        default: begin
          if (started) begin
            record_check(3, pending > 0 && trace_status == pending_kind,
                         $sformatf("unexpected %s cycle before pc %h",
                                   trace_status.name(), model_pc));
            if (pending > 0) begin
              pending--;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== test/riscv_core_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscv_core_assertions import riscv_pkg::*; (
  input logic          clk,
  input logic          rst,
  input logic          store_en,
  input logic          halt,
  input cycle_status_e trace_status,
  input logic          branch_taken,
  input word_t         branch_target,
  input word_t         imem_addr,
  input decode_state_t decode_state
);

  int failure_count = 0;

  // one reset edge has passed, so the stage registers are known
  quiet_in_reset: assert property (@(posedge clk) rst ##1 rst |-> !store_en && !halt)
    else begin
      failure_count++;
      $error("store_en or halt high during reset");
    end

  status_legal: assert property (@(posedge clk) disable iff (rst)
    trace_status inside {cycle_reset, cycle_no_stall, cycle_taken_branch, cycle_load2use})
    else begin
      failure_count++;
      $error("trace_status holds an unknown value");
    end

  // the branch redirects fetch and squashes decode instead of holding it
  branch_wins: assert property (@(posedge clk) disable iff (rst)
    branch_taken |=> decode_state.cycle_status == cycle_taken_branch
                     && imem_addr == $past(branch_target))
    else begin
      failure_count++;
      $error("taken branch did not flush decode and redirect the pc");
    end

endmodule

bind riscv_core riscv_core_assertions i_riscv_core_assertions (
  .clk           (clk),
  .rst           (rst),
  .store_en      (store_en),
  .halt          (halt),
  .trace_status  (trace_status),
  .branch_taken  (branch_taken),
  .branch_target (branch_target),
  .imem_addr     (imem_addr),
  .decode_state  (decode_state)
);

`default_nettype wire

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_core import riscv_pkg::*; ();

  localparam int num_insns = 200;
  // three cycles per instruction plus pipeline fill
  localparam int cycle_limit = 3 * num_insns + 30;

  logic          clk;
  logic          rst;
  word_t         imem_addr;
  insn_t         insn_data;
  word_t         dmem_addr;
  word_t         load_data;
  word_t         store_data;
  logic          store_en;
  logic          halt;
  word_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  logic          trace_reg_we;
  reg_idx_t      trace_rd;
  word_t         trace_rd_data;
  logic          finished;
  int            error_count;
  int            check_count;
  int            total_errors;
  int            cycles;
  insn_t         imem [256];
  word_t         dmem [64];

  // registers x0 to x7 only, so the bypass paths fire often
  function automatic insn_t random_insn(input int idx);
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] off;
    int          kind;
    rd = 5'($urandom % 8);
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    f3 = 3'($urandom);
    imm = 12'($urandom);
    f7 = ($urandom % 2) ? 7'b0100000 : 7'd0;
    kind = $urandom % 16;
    // a branch this close to the end would jump over the ecall
    if (kind >= 14 && idx > num_insns - 3) begin
      kind = 0;
    end
    if (kind <= 4) begin
      if (f3 == 3'b001) begin
        imm[11:5] = 7'd0;
      end else if (f3 == 3'b101) begin
        imm[11:5] = f7;
      end
      return {imm, rs1, f3, rd, op_reg_imm};
    end else if (kind <= 7) begin
      if (f3 != 3'b000 && f3 != 3'b101) begin
        f7 = 7'd0;
      end
      return {f7, rs2, rs1, f3, rd, op_reg_reg};
    end else if (kind == 8) begin
      return {20'($urandom), rd, op_lui};
    end else if (kind <= 11) begin
      return {4'd0, 6'($urandom % 64), 2'd0, 5'd0, 3'b010, rd, op_load};
    end else if (kind <= 13) begin
      imm = {4'd0, 6'($urandom % 64), 2'd0};
      return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store};
    end
    off = ($urandom % 2) ? 13'd8 : 13'd12;
    kind = $urandom % 6;
    f3 = (kind < 2) ? 3'(kind) : 3'(kind + 2);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  riscv_core #(
    .num_regs (32)
  ) i_riscv_core (
    .clk           (clk),
    .rst           (rst),
    .imem_addr     (imem_addr),
    .insn_data     (insn_data),
    .dmem_addr     (dmem_addr),
    .load_data     (load_data),
    .store_data    (store_data),
    .store_en      (store_en),
    .halt          (halt),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_reg_we  (trace_reg_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

  riscv_checker #(
    .num_insns (num_insns)
  ) i_riscv_checker (
    .clk           (clk),
    .rst           (rst),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_reg_we  (trace_reg_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data),
    .halt          (halt),
    .store_en      (store_en),
    .dmem_addr     (dmem_addr),
    .store_data    (store_data),
    .finished      (finished),
    .error_count   (error_count),
    .check_count   (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // memories answer within the cycle
  assign insn_data = imem[imem_addr[9:2]];
  assign load_data = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    if (store_en) begin
      dmem[dmem_addr[7:2]] <= store_data;
    end
  end

  initial begin
    rst = 1'b1;
    void'($urandom(67));
    // everything past the program is ecall
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < num_insns) ? random_insn(i) : {25'd0, op_environ};
      i_riscv_checker.program_copy[i] = imem[i];
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i] = 32'hd000_0000 + i * 32'h0001_0011;
      i_riscv_checker.model_dmem[i] = dmem[i];
    end
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    cycles = 10;
    while (finished !== 1'b1 && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (finished !== 1'b1) begin
      $display("halt never came within %0d cycles, so the run was stopped", cycle_limit);
    end
    total_errors = error_count + i_riscv_core.i_riscv_core_assertions.failure_count;
    $display("%0d checks, %0d errors, %0d cycles", check_count, total_errors, cycles);
    if (finished === 1'b1 && total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
